//--- verilog/cpu_config.svh
// datapath widths and sizes for the single-cycle cpu
// instruction field positions assume a 16-bit code word
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// register and alu data width
`define CPU_DATA_W 32

// program counter and branch target
`define CPU_PC_W 8

// instruction word
`define CPU_CODE_W 16

// register file
`define CPU_REG_ADDR_W 4
`define CPU_NUM_REGS 16

// shift amount comes from the low bits of operand b
`define CPU_SHAMT_W 5

// loadi immediate, zero-extended on write
`define CPU_IMM_W 8

`endif

//--- verilog/cpu_pkg.sv
// shared types for the cpu
// alu_op_e sits in code[14:12] when code[15] is 0
// instr_class_e is code[15:12] when code[15] is 1
`include "cpu_config.svh"

package cpu_pkg;

   typedef logic [`CPU_PC_W-1:0] pc_t;

   typedef enum logic [2:0] {
      ALU_SLL   = 3'b000,
      ALU_SRL   = 3'b001,
      ALU_ADD   = 3'b010,
      ALU_SUB   = 3'b011,
      ALU_AND   = 3'b100,
      ALU_XNOR  = 3'b101,
      ALU_RSVD6 = 3'b110, // result is zero
      ALU_RSVD7 = 3'b111
   } alu_op_e;

   // codes 1011 to 1110 are not listed and act as no-ops
   typedef enum logic [3:0] {
      OP_JZ    = 4'b1000,
      OP_JNZ   = 4'b1001,
      OP_LOADI = 4'b1010,
      OP_STOP  = 4'b1111
   } instr_class_e;

endpackage

//--- verilog/alu.sv
// 32-bit alu, result is combinational
// shifts are logical and use only b[4:0]
// ops 110 and 111 give zero
`include "cpu_config.svh"

module alu
   import cpu_pkg::*;
(
   input  logic [`CPU_DATA_W-1:0] a,
   input  logic [`CPU_DATA_W-1:0] b,
   input  alu_op_e                op,
   output logic [`CPU_DATA_W-1:0] result
);

   localparam int W = `CPU_DATA_W;

   logic [`CPU_SHAMT_W-1:0] shamt;
   logic [W-1:0]            sll_res;
   logic [W-1:0]            srl_res;
   logic                    sub;
   logic [W-1:0]            b_in;
   logic [W-1:0]            sum;
   logic [W-1:0]            and_res;
   logic [W-1:0]            xnor_res;

   assign shamt   = b[`CPU_SHAMT_W-1:0];
   assign sll_res = a << shamt; // zero fill
   assign srl_res = a >> shamt;

   // subtract as a + ~b + 1, carry out dropped
   assign sub  = (op == ALU_SUB);
   assign b_in = sub ? ~b : b;
   assign sum  = a + b_in + {{(W-1){1'b0}}, sub};

   assign and_res  = a & b;
   assign xnor_res = ~(a ^ b);

   always_comb begin
      case (op)
         ALU_SLL:   result = sll_res;
         ALU_SRL:   result = srl_res;
         ALU_ADD:   result = sum;
         ALU_SUB:   result = sum;
         ALU_AND:   result = and_res;
         ALU_XNOR:  result = xnor_res;
         ALU_RSVD6: result = '0;
         ALU_RSVD7: result = '0;
         default:   result = '0;
      endcase
   end

endmodule

//--- verilog/reg_file.sv
// 16 x 32 register file, two async read ports, one sync write port
// a write shows on the read ports from the next cycle on
`include "cpu_config.svh"

module reg_file (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       write_en,
   input  logic [`CPU_REG_ADDR_W-1:0] addr_s,
   input  logic [`CPU_REG_ADDR_W-1:0] addr_a,
   input  logic [`CPU_REG_ADDR_W-1:0] addr_b,
   input  logic [`CPU_DATA_W-1:0]     wr_data,
   output logic [`CPU_DATA_W-1:0]     rd_a,
   output logic [`CPU_DATA_W-1:0]     rd_b
);

   logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            regs[i] <= '0; // all registers read zero after reset
         end
      end else if (write_en) begin
         regs[addr_s] <= wr_data;
      end
   end

   // combinational reads
   assign rd_a = regs[addr_a];
   assign rd_b = regs[addr_b];

endmodule

//--- verilog/instr_decoder.sv
// purely combinational decode of one instruction word
// branch condition uses rd_a, so register a must be read before it settles
`include "cpu_config.svh"

module instr_decoder
   import cpu_pkg::*;
(
   input  logic [`CPU_CODE_W-1:0]     code,
   input  logic [`CPU_DATA_W-1:0]     rd_a,
   output logic [`CPU_REG_ADDR_W-1:0] addr_s,
   output logic [`CPU_REG_ADDR_W-1:0] addr_a,
   output logic [`CPU_REG_ADDR_W-1:0] addr_b,
   output alu_op_e                    alu_op,
   output logic [`CPU_IMM_W-1:0]      imm,
   output pc_t                        branch_pc,
   output logic                       write_en,
   output logic                       imm_en,
   output logic                       branch_en,
   output logic                       stop_en
);

   instr_class_e cls;
   logic         is_alu;
   logic         a_zero;

   assign is_alu = ~code[15];
   assign cls    = instr_class_e'(code[15:12]);
   assign alu_op = alu_op_e'(code[14:12]);

   assign addr_s    = code[11:8];
   assign addr_a    = code[7:4];
   assign addr_b    = code[3:0];
   assign imm       = code[7:0];
   assign branch_pc = {code[11:8], code[3:0]}; // target split around reg a

   assign a_zero = (rd_a == '0);

   always_comb begin
      write_en  = is_alu;
      imm_en    = 1'b0;
      branch_en = 1'b0;
      stop_en   = 1'b0;
      if (!is_alu) begin
         case (cls)
            OP_LOADI: begin
               imm_en   = 1'b1;
               write_en = 1'b1;
            end
            OP_JZ:    branch_en = a_zero;
            OP_JNZ:   branch_en = ~a_zero;
            OP_STOP:  stop_en   = 1'b1;
            default: begin
               // no-op, pc just advances
               write_en = 1'b0;
            end
         endcase
      end
   end

endmodule

//--- verilog/pc_counter.sv
// program counter, one step per clock
// next_pc is forced to zero while rst_n is low
// stop has priority over branch, branch over increment
`include "cpu_config.svh"

module pc_counter
   import cpu_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic branch_en,
   input  logic stop_en,
   input  pc_t  branch_pc,
   output pc_t  pc,
   output pc_t  next_pc
);

   pc_t pc_inc;

   assign pc_inc = pc + 1'b1; // wraps at 255

   always_comb begin
      if (!rst_n) begin
         next_pc = '0;
      end else if (stop_en) begin
         next_pc = pc; // hold on stop word
      end else if (branch_en) begin
         next_pc = branch_pc;
      end else begin
         next_pc = pc_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= next_pc;
      end
   end

endmodule

//--- verilog/cpu_top.sv
// single-cycle cpu, one instruction per clock
// code must be valid for the current pc within the same cycle
// instruction memory lives outside and sees only pc
`include "cpu_config.svh"

module cpu_top
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`CPU_CODE_W-1:0] code,
   output pc_t                    pc,
   output pc_t                    next_pc,
   output logic [`CPU_DATA_W-1:0] mem_s,
   output logic                   write_en,
   output logic                   imm_en,
   output logic                   branch_en
);

   logic [`CPU_REG_ADDR_W-1:0] addr_s;
   logic [`CPU_REG_ADDR_W-1:0] addr_a;
   logic [`CPU_REG_ADDR_W-1:0] addr_b;
   alu_op_e                    alu_op;
   logic [`CPU_IMM_W-1:0]      imm;
   pc_t                        branch_pc;
   logic                       stop_en;
   logic [`CPU_DATA_W-1:0]     rd_a;
   logic [`CPU_DATA_W-1:0]     rd_b;
   logic [`CPU_DATA_W-1:0]     alu_res;
   logic [`CPU_DATA_W-1:0]     imm_ext;

   instr_decoder dec_i (
      .code      (code),
      .rd_a      (rd_a),
      .addr_s    (addr_s),
      .addr_a    (addr_a),
      .addr_b    (addr_b),
      .alu_op    (alu_op),
      .imm       (imm),
      .branch_pc (branch_pc),
      .write_en  (write_en),
      .imm_en    (imm_en),
      .branch_en (branch_en),
      .stop_en   (stop_en)
   );

   pc_counter pc_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .branch_en (branch_en),
      .stop_en   (stop_en),
      .branch_pc (branch_pc),
      .pc        (pc),
      .next_pc   (next_pc)
   );

   reg_file rf_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .write_en (write_en),
      .addr_s   (addr_s),
      .addr_a   (addr_a),
      .addr_b   (addr_b),
      .wr_data  (mem_s), // write back whatever goes out on mem_s
      .rd_a     (rd_a),
      .rd_b     (rd_b)
   );

   alu alu_i (
      .a      (rd_a),
      .b      (rd_b),
      .op     (alu_op),
      .result (alu_res)
   );

   assign imm_ext = {{(`CPU_DATA_W - `CPU_IMM_W){1'b0}}, imm};
   assign mem_s   = imm_en ? imm_ext : alu_res; // loadi bypasses the alu

endmodule

//--- test/cpu_assert.sv
// port-level checks on cpu_top, attached by bind
// stop and exclusivity rules are skipped while rst_n is low
`include "cpu_config.svh"

module cpu_assert
   import cpu_pkg::*;
(
   input logic                   clk,
   input logic                   rst_n,
   input logic [`CPU_CODE_W-1:0] code,
   input pc_t                    pc,
   input pc_t                    next_pc,
   input logic                   write_en,
   input logic                   imm_en,
   input logic                   branch_en
);

   logic is_stop;

   assign is_stop = (code[15:12] == OP_STOP);

   // a reset edge leaves pc at zero
   pc_after_reset: assert property (@(posedge clk) !rst_n |=> (pc == '0))
      else $error("pc is not zero after a reset cycle");

   stop_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      is_stop |-> (next_pc == pc))
      else $error("stop word did not hold pc");

   imm_implies_write: assert property (@(posedge clk) disable iff (!rst_n)
      imm_en |-> write_en)
      else $error("imm_en high without write_en");

   write_branch_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(write_en && branch_en))
      else $error("write_en and branch_en high together");

endmodule

bind cpu_top cpu_assert assert_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .code      (code),
   .pc        (pc),
   .next_pc   (next_pc),
   .write_en  (write_en),
   .imm_en    (imm_en),
   .branch_en (branch_en)
);

//--- test/cpu_tb.sv
// random programs for cpu_top checked against a cycle-level model
// programs come from a 16-bit Galois LFSR, identical on every run
// code changes DRIVE_DLY after the rising edge, outputs compared at the falling edge
`include "cpu_config.svh"

module cpu_tb
   import cpu_pkg::*;
();

   localparam int CLK_PERIOD     = 40;
   localparam int DRIVE_DLY      = 2;
   localparam int RST_CYCLES     = 3;
   localparam int NUM_PROGS      = 8;
   localparam int PROG_CYCLES    = 300;
   localparam int PROG_WORDS     = 256;
   // 8 x (300 + 3) = 2424 cycles, plus margin
   localparam int TIMEOUT_CYCLES = 3000;

   logic                   clk;
   logic                   rst_n;
   logic [`CPU_CODE_W-1:0] code;
   pc_t                    pc;
   pc_t                    next_pc;
   logic [`CPU_DATA_W-1:0] mem_s;
   logic                   write_en;
   logic                   imm_en;
   logic                   branch_en;

   logic [`CPU_CODE_W-1:0] prog [PROG_WORDS];
   logic [15:0]            lfsr;
   int                     cycle_cnt = 0;
   int                     n_write   = 0;
   int                     n_branch  = 0;
   int                     n_hold    = 0;

   // model state and the prediction for the current cycle
   logic [`CPU_DATA_W-1:0]     m_regs [`CPU_NUM_REGS];
   pc_t                        m_pc;
   logic [`CPU_DATA_W-1:0]     exp_res;
   pc_t                        exp_next;
   logic [`CPU_REG_ADDR_W-1:0] exp_dst;
   logic                       exp_we;
   logic                       exp_imm;
   logic                       exp_br;

   cpu_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .code      (code),
      .pc        (pc),
      .next_pc   (next_pc),
      .mem_s     (mem_s),
      .write_en  (write_en),
      .imm_en    (imm_en),
      .branch_en (branch_en)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run;
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[30:0], lfsr[0]}; // one step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // 5 bits pick the class: 0 stop, 1-16 alu, 17-22 loadi,
   // 23-25 jz, 26-28 jnz, 29-31 no-op
   task automatic gen_program;
      logic [31:0] sel;
      logic [31:0] sub;
      logic [31:0] fld;
      logic [3:0]  op4;
      for (int i = 0; i < PROG_WORDS; i++) begin
         rand_bits(5, sel);
         if (sel == 0) begin
            op4 = OP_STOP;
         end else if (sel <= 16) begin
            rand_bits(3, sub);
            op4 = {1'b0, sub[2:0]};
         end else if (sel <= 22) begin
            op4 = OP_LOADI;
         end else if (sel <= 25) begin
            op4 = OP_JZ;
         end else if (sel <= 28) begin
            op4 = OP_JNZ;
         end else begin
            rand_bits(2, sub);
            op4 = 4'b1011 + {2'b00, sub[1:0]}; // 1011 to 1110
         end
         rand_bits(12, fld);
         prog[i] = {op4, fld[11:0]};
      end
      // first word adds two registers that reset just cleared
      prog[0][15:12] = {1'b0, ALU_ADD};
   endtask

   task automatic predict(input logic [`CPU_CODE_W-1:0] c);
      logic [`CPU_DATA_W-1:0] a;
      logic [`CPU_DATA_W-1:0] b;
      logic                   stop;
      a       = m_regs[c[7:4]];
      b       = m_regs[c[3:0]];
      stop    = 1'b0;
      exp_we  = 1'b0;
      exp_imm = 1'b0;
      exp_br  = 1'b0;
      exp_res = '0;
      exp_dst = c[11:8];
      if (!c[15]) begin
         exp_we = 1'b1;
         case (c[14:12])
            ALU_SLL:  exp_res = a << b[4:0];
            ALU_SRL:  exp_res = a >> b[4:0];
            ALU_ADD:  exp_res = a + b;
            ALU_SUB:  exp_res = a - b;
            ALU_AND:  exp_res = a & b;
            ALU_XNOR: exp_res = ~(a ^ b);
            default:  exp_res = '0; // 110 and 111 still write
         endcase
      end else begin
         case (c[15:12])
            OP_LOADI: begin
               exp_we  = 1'b1;
               exp_imm = 1'b1;
               exp_res = 32'(c[7:0]);
            end
            OP_JZ:   exp_br = (a == '0);
            OP_JNZ:  exp_br = (a != '0);
            OP_STOP: stop   = 1'b1;
            default: stop   = 1'b0; // no-op
         endcase
      end
      if (stop) begin
         exp_next = m_pc;
      end else if (exp_br) begin
         exp_next = {c[11:8], c[3:0]};
      end else begin
         exp_next = pc_t'(m_pc + 8'd1);
      end
   endtask

   task automatic apply_reset;
      rst_n = 1'b0;
      code  = '0;
      repeat (RST_CYCLES) begin
         @(posedge clk);
         #(DRIVE_DLY);
         check_val("next_pc in reset", 32'(next_pc), 32'd0);
         check_val("pc in reset", 32'(pc), 32'd0);
      end
      rst_n = 1'b1;
      m_pc  = '0;
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
         m_regs[i] = '0;
      end
   endtask

   // entered just after a rising edge
   task automatic run_cycle;
      code = prog[pc]; // fetch at the dut's pc
      @(negedge clk);
      predict(prog[m_pc]);
      check_val("pc", 32'(pc), 32'(m_pc));
      check_val("next_pc", 32'(next_pc), 32'(exp_next));
      check_val("write_en", 32'(write_en), 32'(exp_we));
      check_val("imm_en", 32'(imm_en), 32'(exp_imm));
      check_val("branch_en", 32'(branch_en), 32'(exp_br));
      if (exp_we) begin
         check_val("mem_s", mem_s, exp_res);
      end
      @(posedge clk);
      if (exp_we) begin
         m_regs[exp_dst] = exp_res;
         n_write++;
      end
      if (exp_br) begin
         n_branch++;
      end
      if (exp_next == m_pc) begin
         n_hold++;
      end
      m_pc = exp_next;
      #(DRIVE_DLY);
   endtask

   initial begin
      rst_n = 1'b0;
      code  = '0;
      lfsr  = 16'd30220;
      for (int p = 0; p < NUM_PROGS; p++) begin
         gen_program();
         apply_reset();
         repeat (PROG_CYCLES) begin
            run_cycle();
         end
      end
      $display("%0d programs run: %0d writes, %0d branches, %0d cycles with pc held",
               NUM_PROGS, n_write, n_branch, n_hold);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- all.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/pc_counter.sv
verilog/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run, exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cpu_tb -f all.f -o cpu_sim \
   && ./obj_dir/cpu_sim \
   && echo "simulation finished" \
   || { echo "build or simulation failed"; exit 1; }
